/* vlog.f */
design/fetch_pkg.sv
design/fetch_pc_select.sv
design/fetch_request.sv
design/fetch_response.sv
design/fetch_unit.sv
sim/fetch_clk_gen.sv
sim/fetch_asserts.sv
sim/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_tb -f vlog.f -o fetch_sim

out=$(./obj_dir/fetch_sim +verilator+error+limit+100 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    exit 0
fi
exit 1

/* sim/fetch_tb.sv */
`timescale 1ns/10ps

module fetch_tb import fetch_pkg::*; ();

    localparam addr_t RESET_PC    = 64'h8000_0000;
    localparam int    BUF_DEPTH   = 4;
    localparam int    NUM_ROWS    = 9;
    localparam int    TAIL_OUTS   = 8;
    localparam int    CYCLE_LIMIT = 40 * NUM_ROWS + 200;
    localparam inst_t WORD_XOR    = 32'h1300_0000;
    localparam addr_t DECOY_JALR  = 64'hA000_0000;   // loses against the branch
    localparam addr_t DECOY_TRAP  = 64'hB000_0000;

    typedef struct packed {
        addr_t       trig_pc;
        redir_kind_t kind;
        logic        all_kinds;   // raise jalr and trap along with the branch
        addr_t       op_a;        // branch pc, jalr base or trap vector
        addr_t       op_b;        // branch or jalr immediate
        addr_t       target;      // first pc expected after the redirect
    } redir_row_t;

    logic  clk;
    logic  rst_n;
    logic  br_take;
    addr_t br_pc;
    addr_t br_imm;
    logic  jalr;
    addr_t jalr_base;
    addr_t jalr_imm;
    logic  trap;
    addr_t trap_vec;
    logic  mem_req_valid;
    logic  mem_req_ready;
    addr_t mem_req_addr;
    logic  mem_rsp_valid;
    inst_t mem_rsp_data;
    logic  out_valid;
    addr_t out_pc;
    inst_t out_inst;
    logic  out_ready;

    redir_row_t rows [NUM_ROWS];
    addr_t      pend_addr [$];   // memory requests waiting for their response
    int         pend_due  [$];
    int         last_due;
    int         cyc;
    int         cycle_cnt;
    integer     seed;
    addr_t      exp_pc;
    int         err_cnt;
    int         fail_tests;
    int         redir_row;       // row applied this cycle, -1 if none
    logic       out_seen;
    addr_t      seen_pc;
    logic       rst_done;        // first cycle after reset already checked

    fetch_clk_gen u_clk_gen (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    fetch_unit #(
        .RESET_PC  (RESET_PC),
        .BUF_DEPTH (BUF_DEPTH)
    ) UUT (
        .clk             (clk),
        .rst_n_i         (rst_n),
        .br_take_i       (br_take),
        .br_pc_i         (br_pc),
        .br_imm_i        (br_imm),
        .jalr_i          (jalr),
        .jalr_base_i     (jalr_base),
        .jalr_imm_i      (jalr_imm),
        .trap_i          (trap),
        .trap_vec_i      (trap_vec),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_addr_o  (mem_req_addr),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_data_i  (mem_rsp_data),
        .out_valid_o     (out_valid),
        .out_pc_o        (out_pc),
        .out_inst_o      (out_inst),
        .out_ready_i     (out_ready)
    );

    // memory content is a fixed function of the address
    function automatic inst_t mem_word(input addr_t addr);
        return addr[31:0] ^ WORD_XOR;
    endfunction

    task automatic add_row(input int idx, input addr_t trig, input redir_kind_t kind,
                           input logic all_kinds, input addr_t op_a, input addr_t op_b,
                           input addr_t target);
        rows[idx].trig_pc   = trig;
        rows[idx].kind      = kind;
        rows[idx].all_kinds = all_kinds;
        rows[idx].op_a      = op_a;
        rows[idx].op_b      = op_b;
        rows[idx].target    = target;
    endtask

    task automatic clear_redirect();
        br_take   = 1'b0;
        br_pc     = '0;
        br_imm    = '0;
        jalr      = 1'b0;
        jalr_base = '0;
        jalr_imm  = '0;
        trap      = 1'b0;
        trap_vec  = '0;
    endtask

    task automatic apply_redirect(input int r);
        case (rows[r].kind)
            redir_branch: begin
                br_take = 1'b1;
                br_pc   = rows[r].op_a;
                br_imm  = rows[r].op_b;
            end
            redir_jalr: begin
                jalr      = 1'b1;
                jalr_base = rows[r].op_a;
                jalr_imm  = rows[r].op_b;
            end
            redir_trap: begin
                trap     = 1'b1;
                trap_vec = rows[r].op_a;
            end
            default: ;
        endcase
        if (rows[r].all_kinds) begin
            jalr      = 1'b1;
            jalr_base = DECOY_JALR;
            jalr_imm  = 64'h4;
            trap      = 1'b1;
            trap_vec  = DECOY_TRAP;
        end
    endtask

    task automatic accept_request(input addr_t addr);
        int rnd;
        int due;
        rnd = $random(seed);
        due = cyc + 1 + (rnd & 3);   // 1 to 4 cycles later
        if (due <= last_due) begin
            due = last_due + 1;      // in order, one per cycle
        end
        last_due = due;
        pend_addr.push_back(addr);
        pend_due.push_back(due);
    endtask

    task automatic check_output();
        inst_t exp_inst;
        exp_inst = mem_word(exp_pc);
        if (out_pc !== exp_pc) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: output pc %h, expected %h", $time, out_pc, exp_pc);
        end
        if (out_inst !== exp_inst) begin
            err_cnt++;
            $display("CHECK FAILED at %0t: word %h at pc %h, expected %h",
                     $time, out_inst, out_pc, exp_inst);
        end
        exp_pc = exp_pc + 64'h4;
    endtask

    // nothing valid in reset, then the reset pc is requested at once
    task automatic check_reset();
        if (!rst_n) begin
            if (mem_req_valid !== 1'b0 || out_valid !== 1'b0) begin
                err_cnt++;
                $display("CHECK FAILED at %0t: valid raised during reset", $time);
            end
        end else if (!rst_done) begin
            rst_done = 1'b1;
            if (mem_req_valid !== 1'b1 || mem_req_addr !== RESET_PC) begin
                err_cnt++;
                $display("CHECK FAILED at %0t: first request valid %b addr %h, expected %h",
                         $time, mem_req_valid, mem_req_addr, RESET_PC);
            end
        end
    endtask

    // drive just after the edge, sample at the falling edge
    task automatic run_cycle();
        int rnd;
        @(posedge clk);
        #1;
        cyc++;
        if (pend_due.size() > 0 && pend_due[0] <= cyc) begin
            mem_rsp_valid = 1'b1;
            mem_rsp_data  = mem_word(pend_addr[0]);
            pend_addr.delete(0);
            pend_due.delete(0);
        end else begin
            mem_rsp_valid = 1'b0;
            mem_rsp_data  = '0;
        end
        rnd           = $random(seed);
        mem_req_ready = (rnd & 3) != 0;   // ready 3 cycles in 4
        rnd           = $random(seed);
        out_ready     = rnd[0];
        clear_redirect();
        if (redir_row >= 0) begin
            apply_redirect(redir_row);
        end
        @(negedge clk);
        check_reset();
        if (mem_req_valid && mem_req_ready) begin
            accept_request(mem_req_addr);
        end
        out_seen = out_valid && out_ready;
        seen_pc  = out_pc;
        if (out_seen) begin
            check_output();   // this transfer is still on the old path
        end
        if (redir_row >= 0 && rows[redir_row].kind != redir_none) begin
            exp_pc = rows[redir_row].target;
        end
    endtask

    task automatic wait_for_pc(input addr_t pc);
        run_cycle();
        while (!(out_seen && seen_pc == pc)) begin
            run_cycle();
        end
    endtask

    task automatic wait_for_output();
        run_cycle();
        while (!out_seen) begin
            run_cycle();
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: ok", name);
        end else begin
            fail_tests++;
            $display("%s: failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int row_errs;
        int assert_errs;
        clear_redirect();
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        out_ready     = 1'b0;
        seed          = 7;
        exp_pc        = RESET_PC;
        err_cnt       = 0;
        fail_tests    = 0;
        cyc           = 0;
        cycle_cnt     = 0;
        last_due      = 0;
        redir_row     = -1;
        out_seen      = 1'b0;
        seen_pc       = '0;
        rst_done      = 1'b0;

        // trigger, kind, all, operand a, operand b, expected target
        add_row(0, 64'h8000_0030, redir_none, 1'b0, '0, '0, '0);
        add_row(1, 64'h8000_0040, redir_branch, 1'b0, 64'h8000_0040, 64'h100,
                64'h8000_0140);
        add_row(2, 64'h8000_0150, redir_jalr, 1'b0, 64'h9000_0000, 64'h21,
                64'h9000_0020);   // odd sum
        add_row(3, 64'h9000_0038, redir_trap, 1'b0, 64'h8000_1000, '0, 64'h8000_1000);
        add_row(4, 64'h8000_1010, redir_branch, 1'b1, 64'h8000_1010,
                64'hFFFF_FFFF_FFFF_FF00, 64'h8000_0F10);
        add_row(5, 64'h8000_0F14, redir_branch, 1'b0, 64'h8000_0F14, 64'h1000_0000,
                64'h9000_0F14);
        add_row(6, 64'h9000_0F18, redir_jalr, 1'b0, 64'h1_0000_0000, 64'h5,
                64'h1_0000_0004);
        add_row(7, 64'h1_0000_0008, redir_trap, 1'b0, 64'h8000_0000, '0, 64'h8000_0000);
        add_row(8, 64'h8000_0020, redir_none, 1'b0, '0, '0, '0);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_errs = err_cnt;
            wait_for_pc(rows[r].trig_pc);
            redir_row = r;
            run_cycle();   // redirect sampled at the end of this cycle
            redir_row = -1;
            wait_for_output();
            if (rows[r].kind != redir_none && seen_pc !== rows[r].target) begin
                err_cnt++;
                $display("CHECK FAILED at %0t: first pc after redirect %h, expected %h",
                         $time, seen_pc, rows[r].target);
            end
            report_test($sformatf("row %0d %s at %h", r, rows[r].kind.name(),
                                  rows[r].trig_pc), row_errs);
        end

        // fetch must keep going once all credits are back
        row_errs = err_cnt;
        for (int n = 0; n < TAIL_OUTS; n++) begin
            wait_for_output();
        end
        report_test("sequential run after redirects", row_errs);

        assert_errs = UUT.u_asserts.fail_cnt;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 NUM_ROWS + 1, fail_tests, err_cnt, assert_errs);
        if (fail_tests == 0 && err_cnt == 0 && assert_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* sim/fetch_asserts.sv */
`timescale 1ns/10ps

module fetch_asserts import fetch_pkg::*; #(
    parameter int BUF_DEPTH = 4
) (
    input logic      clk,
    input logic      rst_n_i,
    input logic      br_take_i,
    input logic      jalr_i,
    input logic      trap_i,
    input logic      redirect_i,
    input logic      mem_req_valid_i,
    input logic      mem_req_ready_i,
    input addr_t     mem_req_addr_i,
    input logic      out_valid_i,
    input logic      out_ready_i,
    input addr_t     out_pc_i,
    input inst_t     out_inst_i,
    input slot_cnt_t credit_i
);

    int fail_cnt = 0;   // failed assertions so far

    // a waiting request keeps its address unless fetch was redirected
    req_addr_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (mem_req_valid_i && !mem_req_ready_i) |=>
            (redirect_i || (mem_req_valid_i && $stable(mem_req_addr_i))))
        else begin
            fail_cnt++;
            $error("request address or valid changed while waiting for ready");
        end

    out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (out_valid_i && !out_ready_i) |=>
            (redirect_i || (out_valid_i && $stable(out_pc_i) && $stable(out_inst_i))))
        else begin
            fail_cnt++;
            $error("decode output changed under back-pressure");
        end

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        credit_i <= slot_cnt_t'(BUF_DEPTH))
        else begin
            fail_cnt++;
            $error("credit count above buffer depth");
        end

    // redirect inputs sampled on an edge leave the next cycle without a request
    no_req_on_redirect: assert property (@(posedge clk) disable iff (!rst_n_i)
        (br_take_i || jalr_i || trap_i) |=> !mem_req_valid_i)
        else begin
            fail_cnt++;
            $error("request offered in the redirect cycle");
        end

endmodule

bind fetch_unit fetch_asserts #(
    .BUF_DEPTH (BUF_DEPTH)
) u_asserts (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .br_take_i       (br_take_i),
    .jalr_i          (jalr_i),
    .trap_i          (trap_i),
    .redirect_i      (redirect),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_i  (mem_req_addr_o),
    .out_valid_i     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .out_pc_i        (out_pc_o),
    .out_inst_i      (out_inst_o),
    .credit_i        (u_request.credit_q)
);

/* sim/fetch_clk_gen.sv */
`timescale 1ns/10ps

module fetch_clk_gen #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // release 1 ns after an edge, like the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n_o = 1'b1;
    end

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/10ps

module fetch_unit import fetch_pkg::*; #(
    parameter addr_t RESET_PC  = 64'h8000_0000,
    parameter int    BUF_DEPTH = 4               // 2 to 4 slots
) (
    input  logic  clk,
    input  logic  rst_n_i,

    // redirect from execute
    input  logic  br_take_i,
    input  addr_t br_pc_i,
    input  addr_t br_imm_i,
    input  logic  jalr_i,
    input  addr_t jalr_base_i,
    input  addr_t jalr_imm_i,
    input  logic  trap_i,
    input  addr_t trap_vec_i,

    // instruction memory request and response
    output logic  mem_req_valid_o,
    input  logic  mem_req_ready_i,
    output addr_t mem_req_addr_o,
    input  logic  mem_rsp_valid_i,
    input  inst_t mem_rsp_data_i,

    // towards decode
    output logic  out_valid_o,
    output addr_t out_pc_o,
    output inst_t out_inst_o,
    input  logic  out_ready_i
);

    addr_t     fetch_pc;
    logic      redirect;     // one-cycle flush after a pc load
    logic      req_fire;
    slot_cnt_t credit_ret;

    fetch_pc_select #(
        .RESET_PC (RESET_PC)
    ) u_pc_select (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .br_take_i   (br_take_i),
        .br_pc_i     (br_pc_i),
        .br_imm_i    (br_imm_i),
        .jalr_i      (jalr_i),
        .jalr_base_i (jalr_base_i),
        .jalr_imm_i  (jalr_imm_i),
        .trap_i      (trap_i),
        .trap_vec_i  (trap_vec_i),
        .req_fire_i  (req_fire),
        .fetch_pc_o  (fetch_pc),
        .redirect_o  (redirect)
    );

    fetch_request #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_request (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .fetch_pc_i      (fetch_pc),
        .redirect_i      (redirect),
        .credit_ret_i    (credit_ret),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_addr_o  (mem_req_addr_o),
        .req_fire_o      (req_fire)
    );

    fetch_response #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_response (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_fire_i      (req_fire),
        .req_addr_i      (mem_req_addr_o),   // issued address, recorded on the fire
        .redirect_i      (redirect),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_data_i  (mem_rsp_data_i),
        .out_ready_i     (out_ready_i),
        .out_valid_o     (out_valid_o),
        .out_pc_o        (out_pc_o),
        .out_inst_o      (out_inst_o),
        .credit_ret_o    (credit_ret)
    );

endmodule

/* design/fetch_response.sv */
`timescale 1ns/10ps

module fetch_response import fetch_pkg::*; #(
    parameter int BUF_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  logic      req_fire_i,
    input  addr_t     req_addr_i,
    input  logic      redirect_i,
    input  logic      mem_rsp_valid_i,
    input  inst_t     mem_rsp_data_i,
    input  logic      out_ready_i,
    output logic      out_valid_o,
    output addr_t     out_pc_o,
    output inst_t     out_inst_o,
    output slot_cnt_t credit_ret_o
);

    localparam int PTR_W = (BUF_DEPTH > 2) ? $clog2(BUF_DEPTH) : 1;

    typedef logic [PTR_W-1:0] ptr_t;

    // in-flight queue, one entry per outstanding request
    addr_t                inf_pc_q [BUF_DEPTH];
    logic [BUF_DEPTH-1:0] inf_stale_q;
    ptr_t                 inf_rd_q;
    ptr_t                 inf_wr_q;

    // instruction buffer towards decode
    addr_t     buf_pc_q   [BUF_DEPTH];
    inst_t     buf_inst_q [BUF_DEPTH];
    ptr_t      buf_rd_q;
    ptr_t      buf_wr_q;
    slot_cnt_t buf_cnt_q;

    logic rsp_stale;
    logic rsp_keep;
    logic rsp_drop;
    logic out_fire;

    // wraps at BUF_DEPTH, which need not be a power of two
    function automatic ptr_t ptr_inc(input ptr_t p);
        if (p == ptr_t'(BUF_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // a response during the flush cycle is old-path as well
    assign rsp_stale = inf_stale_q[inf_rd_q] || redirect_i;
    assign rsp_keep  = mem_rsp_valid_i && !rsp_stale;
    assign rsp_drop  = mem_rsp_valid_i && rsp_stale;

    assign out_valid_o = (buf_cnt_q != '0) && !redirect_i;   // hidden while flushing
    assign out_pc_o    = buf_pc_q[buf_rd_q];
    assign out_inst_o  = buf_inst_q[buf_rd_q];
    assign out_fire    = out_valid_o && out_ready_i;

    // a flush hands back every buffered slot at once
    always_comb begin
        if (redirect_i) begin
            credit_ret_o = buf_cnt_q + slot_cnt_t'(rsp_drop);
        end else begin
            credit_ret_o = slot_cnt_t'(out_fire) + slot_cnt_t'(rsp_drop);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            inf_rd_q    <= '0;
            inf_wr_q    <= '0;
            inf_stale_q <= '0;
        end else begin
            if (redirect_i) begin
                inf_stale_q <= '1;   // all issued requests belong to the old path
            end
            if (req_fire_i) begin
                inf_stale_q[inf_wr_q] <= 1'b0;
                inf_wr_q              <= ptr_inc(inf_wr_q);
            end
            if (mem_rsp_valid_i) begin
                inf_rd_q <= ptr_inc(inf_rd_q);   // responses come back in order
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire_i) begin
            inf_pc_q[inf_wr_q] <= req_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            buf_rd_q  <= '0;
            buf_wr_q  <= '0;
            buf_cnt_q <= '0;
        end else if (redirect_i) begin
            buf_rd_q  <= buf_wr_q;   // drop everything buffered
            buf_cnt_q <= '0;
        end else begin
            if (rsp_keep) begin
                buf_wr_q <= ptr_inc(buf_wr_q);
            end
            if (out_fire) begin
                buf_rd_q <= ptr_inc(buf_rd_q);
            end
            buf_cnt_q <= buf_cnt_q + slot_cnt_t'(rsp_keep) - slot_cnt_t'(out_fire);
        end
    end

    // credits guarantee a free slot for every fresh response
    always_ff @(posedge clk) begin
        if (rsp_keep) begin
            buf_pc_q[buf_wr_q]   <= inf_pc_q[inf_rd_q];
            buf_inst_q[buf_wr_q] <= mem_rsp_data_i;
        end
    end

endmodule

/* design/fetch_request.sv */
`timescale 1ns/10ps

module fetch_request import fetch_pkg::*; #(
    parameter int BUF_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n_i,
    input  addr_t     fetch_pc_i,
    input  logic      redirect_i,
    input  slot_cnt_t credit_ret_i,
    input  logic      mem_req_ready_i,
    output logic      mem_req_valid_o,
    output addr_t     mem_req_addr_o,
    output logic      req_fire_o
);

    slot_cnt_t credit_q;      // free slots not yet claimed by a request
    slot_cnt_t credit_used;
    slot_cnt_t credit_next;

    // each request reserves one instruction buffer slot up front,
    // so a response always has somewhere to go
    assign mem_req_valid_o = rst_n_i && (credit_q != '0) && !redirect_i;   // none in reset
    assign mem_req_addr_o  = fetch_pc_i;   // pc only moves on a fire or a redirect
    assign req_fire_o      = mem_req_valid_o && mem_req_ready_i;

    assign credit_used = slot_cnt_t'(req_fire_o);
    assign credit_next = credit_q - credit_used + credit_ret_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            credit_q <= slot_cnt_t'(BUF_DEPTH);
        end else begin
            credit_q <= credit_next;
        end
    end

endmodule

/* design/fetch_pc_select.sv */
`timescale 1ns/10ps

module fetch_pc_select import fetch_pkg::*; #(
    parameter addr_t RESET_PC = 64'h8000_0000
) (
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  br_take_i,
    input  addr_t br_pc_i,
    input  addr_t br_imm_i,
    input  logic  jalr_i,
    input  addr_t jalr_base_i,
    input  addr_t jalr_imm_i,
    input  logic  trap_i,
    input  addr_t trap_vec_i,
    input  logic  req_fire_i,
    output addr_t fetch_pc_o,
    output logic  redirect_o
);

    addr_t       pc_q;
    logic        redirect_q;
    addr_t       br_target;
    addr_t       jalr_sum;
    addr_t       jalr_target;
    redir_kind_t kind;

    assign br_target   = br_pc_i + br_imm_i;
    assign jalr_sum    = jalr_base_i + jalr_imm_i;
    assign jalr_target = {jalr_sum[XLEN-1:1], 1'b0};   // jalr target has bit 0 cleared

    // priority is branch, then jalr, then trap
    always_comb begin
        if (br_take_i) begin
            kind = redir_branch;
        end else if (jalr_i) begin
            kind = redir_jalr;
        end else if (trap_i) begin
            kind = redir_trap;
        end else begin
            kind = redir_none;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q       <= RESET_PC;
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= (kind != redir_none);
            case (kind)
                redir_branch: pc_q <= br_target;
                redir_jalr:   pc_q <= jalr_target;
                redir_trap:   pc_q <= trap_vec_i;
                default: begin
                    if (req_fire_i) begin
                        pc_q <= pc_q + addr_t'(4);   // next sequential word
                    end
                end
            endcase
        end
    end

    assign fetch_pc_o = pc_q;
    assign redirect_o = redirect_q;   // high for the cycle after a pc load

endmodule

/* design/fetch_pkg.sv */
package fetch_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] addr_t;   // fetch pc or memory address
    typedef logic [31:0]     inst_t;   // one instruction word

    // count of buffer slots or request credits
    // 3 bits is enough for BUF_DEPTH up to 4
    typedef logic [2:0] slot_cnt_t;

    // kind of pc redirect coming back from execute
    typedef enum logic [1:0] {
        redir_none,
        redir_branch,   // jal or taken branch
        redir_jalr,
        redir_trap
    } redir_kind_t;

endpackage
